// File: dcache.f
src/dcache_pkg.sv
src/tag_array.sv
src/data_array.sv
src/plru_table.sv
src/dcache_ctrl.sv
src/dcache_top.sv
sim/mem_model.sv
sim/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - src/dcache_pkg.sv
  - src/tag_array.sv
  - src/data_array.sv
  - src/plru_table.sv
  - src/dcache_ctrl.sv
  - src/dcache_top.sv
  - target: simulation
    files:
      - sim/mem_model.sv
      - sim/dcache_tb.sv

// File: sim/dcache_tb.sv
`default_nettype none
`timescale 1ns/1ns

module dcache_tb
    import dcache_pkg::*;
();

    localparam int CLK_PERIOD = 10;
    localparam int NUM_SETS   = 4;
    localparam int NUM_REQS   = 2000;
    localparam int MEM_WORDS  = 256;   // 1 KiB test region

    logic   clk;
    logic   reset;
    logic   req_valid;
    logic   req_write;
    addr_t  req_addr;
    word_t  req_wdata;
    wstrb_t req_wstrb;
    logic   req_ready;
    logic   resp_valid;
    word_t  resp_rdata;
    logic   mem_rd_valid;
    addr_t  mem_rd_addr;
    logic   mem_rd_ready;
    logic   mem_rd_data_valid;
    line_t  mem_rd_data;
    logic   mem_wr_valid;
    addr_t  mem_wr_addr;
    line_t  mem_wr_data;
    logic   mem_wr_ready;

    word_t       ref_mem [MEM_WORDS];
    logic [31:0] rand_state;
    int          error_count;
    int          check_count;
    int          cycle_count;
    int          last_latency;
    int          wb_count;
    addr_t       last_wb_addr;
    logic        refill_seen;   // a refill happened for the newest request
    int          pend_cycle [$];
    logic        pend_write [$];
    addr_t       pend_addr [$];

    dcache_top #(
        .NUM_SETS(NUM_SETS)
    ) UUT (
        .clk              (clk),
        .reset            (reset),
        .req_valid        (req_valid),
        .req_write        (req_write),
        .req_addr         (req_addr),
        .req_wdata        (req_wdata),
        .req_wstrb        (req_wstrb),
        .req_ready        (req_ready),
        .resp_valid       (resp_valid),
        .resp_rdata       (resp_rdata),
        .mem_rd_valid     (mem_rd_valid),
        .mem_rd_addr      (mem_rd_addr),
        .mem_rd_ready     (mem_rd_ready),
        .mem_rd_data_valid(mem_rd_data_valid),
        .mem_rd_data      (mem_rd_data),
        .mem_wr_valid     (mem_wr_valid),
        .mem_wr_addr      (mem_wr_addr),
        .mem_wr_data      (mem_wr_data),
        .mem_wr_ready     (mem_wr_ready)
    );

    mem_model #(
        .MEM_WORDS(MEM_WORDS),
        .SEED     (32'h737c)
    ) mem (
        .clk              (clk),
        .reset            (reset),
        .mem_rd_valid     (mem_rd_valid),
        .mem_rd_addr      (mem_rd_addr),
        .mem_rd_ready     (mem_rd_ready),
        .mem_rd_data_valid(mem_rd_data_valid),
        .mem_rd_data      (mem_rd_data),
        .mem_wr_valid     (mem_wr_valid),
        .mem_wr_addr      (mem_wr_addr),
        .mem_wr_data      (mem_wr_data),
        .mem_wr_ready     (mem_wr_ready)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic word_t pattern_word(input addr_t addr);
        return (addr * 32'h0001_0001) ^ 32'ha5c3_0f96;
    endfunction

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t data, input wstrb_t strb);
        word_t merged;
        merged = old;
        for (int b = 0; b < WORD_WIDTH / 8; b++) begin
            if (strb[b]) begin
                merged[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    function automatic line_t ref_line(input addr_t addr);
        line_t line;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            line[w*WORD_WIDTH +: WORD_WIDTH] = ref_mem[{addr[9:4], 2'b00} + w];
        end
        return line;
    endfunction

    task automatic compare(input string name, input logic [127:0] actual,
                           input logic [127:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0t: %s = %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    // called and returns 1 ns after a rising edge
    task automatic send(input logic write, input addr_t addr, input word_t wdata,
                        input wstrb_t wstrb);
        req_valid = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_wdata = wdata;
        req_wstrb = wstrb;
        do begin
            @(negedge clk);
        end while (!req_ready);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (pend_cycle.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    // A, B, A, C in set 0 must evict B, so A still hits
    task automatic check_lru_eviction();
        int wb_before;
        wb_before = wb_count;
        send(1'b0, 32'h0000_0004, '0, '0);
        send(1'b0, 32'h0000_0048, '0, '0);
        send(1'b0, 32'h0000_0008, '0, '0);
        send(1'b0, 32'h0000_008c, '0, '0);
        wait_idle();
        send(1'b0, 32'h0000_0000, '0, '0);
        wait_idle();
        compare("load A latency", last_latency, 1);
        compare("write-back count", wb_count - wb_before, 0);
    endtask

    task automatic check_dirty_eviction();
        int wb_before;
        wb_before = wb_count;
        send(1'b1, 32'h0000_0114, 32'hdead_beef, 4'b0110);   // dirty line in set 1
        send(1'b0, 32'h0000_0150, '0, '0);
        send(1'b0, 32'h0000_0190, '0, '0);   // evicts the stored line
        wait_idle();
        compare("write-back count", wb_count - wb_before, 1);
        compare("mem_wr_addr", last_wb_addr, 32'h0000_0110);
        send(1'b0, 32'h0000_01d4, '0, '0);   // clean victim
        wait_idle();
        compare("write-back count", wb_count - wb_before, 1);
        send(1'b0, 32'h0000_0114, '0, '0);   // merged word back from memory
        wait_idle();
    endtask

    always @(negedge clk) begin : monitor
        int   latency;
        addr_t addr;
        logic write;
        cycle_count++;
        if (!reset) begin
            if (resp_valid) begin
                if (pend_cycle.size() == 0) begin
                    error_count++;
                    $display("%0t: response with no outstanding request", $time);
                end else begin
                    latency      = cycle_count - pend_cycle.pop_front();
                    write        = pend_write.pop_front();
                    addr         = pend_addr.pop_front();
                    last_latency = latency;
                    if (!write) begin
                        compare("resp_rdata", resp_rdata, ref_mem[addr[9:2]]);
                    end
                    if (!refill_seen) begin
                        compare("hit latency", latency, 1);
                    end
                end
            end
            if (mem_rd_valid && mem_rd_ready) begin
                compare("mem_rd_addr offset", mem_rd_addr[OFFSET_WIDTH-1:0], 0);
            end
            if (mem_rd_data_valid) begin
                refill_seen = 1'b1;
            end
            if (mem_wr_valid && mem_wr_ready) begin
                compare("mem_wr_addr offset", mem_wr_addr[OFFSET_WIDTH-1:0], 0);
                compare("mem_wr_data", mem_wr_data, ref_line(mem_wr_addr));
                wb_count++;
                last_wb_addr = mem_wr_addr;
            end
            if (req_valid && req_ready) begin
                pend_cycle.push_back(cycle_count);
                pend_write.push_back(req_write);
                pend_addr.push_back(req_addr);
                refill_seen = 1'b0;
                if (req_write) begin
                    ref_mem[req_addr[9:2]] = merge_bytes(ref_mem[req_addr[9:2]], req_wdata,
                                                         req_wstrb);
                end
            end
        end
    end

    initial begin
        #((NUM_REQS + 20) * 40 * CLK_PERIOD);
        $display("timeout: requests still outstanding after %0d cycles", cycle_count);
        $display("checks: %0d, errors: %0d", check_count, error_count + 1);
        $display("Regression failed");
        $finish;
    end

    initial begin
        logic [31:0] rnd;
        reset        = 1'b1;
        req_valid    = 1'b0;
        req_write    = 1'b0;
        req_addr     = '0;
        req_wdata    = '0;
        req_wstrb    = '0;
        rand_state   = 32'h737c;
        error_count  = 0;
        check_count  = 0;
        cycle_count  = 0;
        last_latency = 0;
        wb_count     = 0;
        last_wb_addr = '0;
        refill_seen  = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = pattern_word(addr_t'(i * 4));
        end
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        repeat (3) begin   // idle outputs out of reset
            @(negedge clk);
            compare("req_ready", req_ready, 1);
            compare("resp_valid", resp_valid, 0);
            compare("mem_rd_valid", mem_rd_valid, 0);
            compare("mem_wr_valid", mem_wr_valid, 0);
        end
        @(posedge clk);
        #1;

        check_lru_eviction();
        check_dirty_eviction();

        for (int i = 0; i < NUM_REQS; i++) begin
            rnd = next_random();
            repeat (rnd[7:5] == 0 ? rnd[9:8] : 0) begin
                @(posedge clk);
                #1;
            end
            send(rnd[31], {22'd0, rnd[25:18], 2'b00}, next_random(), rnd[13:10]);
        end
        wait_idle();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/mem_model.sv
`default_nettype none
`timescale 1ns/1ns

module mem_model
    import dcache_pkg::*;
#(
    parameter int          MEM_WORDS = 256,
    parameter logic [31:0] SEED      = 32'h1
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  mem_rd_valid,
    input  addr_t mem_rd_addr,
    output logic  mem_rd_ready,
    output logic  mem_rd_data_valid,
    output line_t mem_rd_data,
    input  logic  mem_wr_valid,
    input  addr_t mem_wr_addr,
    input  line_t mem_wr_data,
    output logic  mem_wr_ready
);

    word_t       words [MEM_WORDS];
    logic [31:0] rand_state;
    int          rd_delay;   // -1 while no request is waiting
    int          wr_delay;
    logic        rd_ready_next;
    logic        wr_ready_next;
    logic        rd_data_next;
    line_t       rd_line_next;

    function automatic word_t pattern_word(input addr_t addr);
        return (addr * 32'h0001_0001) ^ 32'ha5c3_0f96;
    endfunction

    // 0 to 3 cycles from the upper LCG bits
    function automatic int draw_delay();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return int'(rand_state[31:30]);
    endfunction

    function automatic int word_index(input addr_t addr);
        return int'(addr[31:2]) % MEM_WORDS;
    endfunction

    initial begin
        rand_state        = SEED;
        rd_delay          = -1;
        wr_delay          = -1;
        mem_rd_ready      = 1'b0;
        mem_wr_ready      = 1'b0;
        mem_rd_data_valid = 1'b0;
        mem_rd_data       = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            words[i] = pattern_word(addr_t'(i * 4));
        end
        forever begin
            @(negedge clk);
            rd_ready_next = 1'b0;
            wr_ready_next = 1'b0;
            rd_data_next  = 1'b0;
            rd_line_next  = mem_rd_data;
            if (!reset && mem_wr_valid && mem_wr_ready) begin
                for (int w = 0; w < WORDS_PER_LINE; w++) begin
                    words[word_index(mem_wr_addr) + w] = mem_wr_data[w*WORD_WIDTH +: WORD_WIDTH];
                end
                wr_delay = -1;
            end else if (!reset && mem_wr_valid) begin
                if (wr_delay < 0) begin
                    wr_delay = draw_delay();
                end
                if (wr_delay == 0) begin
                    wr_ready_next = 1'b1;
                end else begin
                    wr_delay--;
                end
            end
            if (!reset && mem_rd_valid && mem_rd_ready) begin
                for (int w = 0; w < WORDS_PER_LINE; w++) begin
                    rd_line_next[w*WORD_WIDTH +: WORD_WIDTH] = words[word_index(mem_rd_addr) + w];
                end
                rd_data_next = 1'b1;   // line comes back in the next cycle
                rd_delay     = -1;
            end else if (!reset && mem_rd_valid) begin
                if (rd_delay < 0) begin
                    rd_delay = draw_delay();
                end
                if (rd_delay == 0) begin
                    rd_ready_next = 1'b1;
                end else begin
                    rd_delay--;
                end
            end
            @(posedge clk);
            #1;
            mem_rd_ready      = rd_ready_next;
            mem_wr_ready      = wr_ready_next;
            mem_rd_data_valid = rd_data_next;
            mem_rd_data       = rd_line_next;
        end
    end

endmodule

`default_nettype wire

// File: src/dcache_top.sv
`default_nettype none
`timescale 1ns/1ns

module dcache_top
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 16,
    localparam int INDEX_WIDTH = $clog2(NUM_SETS),
    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   req_valid,
    input  logic   req_write,
    input  addr_t  req_addr,
    input  word_t  req_wdata,
    input  wstrb_t req_wstrb,
    output logic   req_ready,
    output logic   resp_valid,
    output word_t  resp_rdata,
    output logic   mem_rd_valid,
    output addr_t  mem_rd_addr,
    input  logic   mem_rd_ready,
    input  logic   mem_rd_data_valid,
    input  line_t  mem_rd_data,
    output logic   mem_wr_valid,
    output addr_t  mem_wr_addr,
    output line_t  mem_wr_data,
    input  logic   mem_wr_ready
);

    logic                   rd_en;
    logic [INDEX_WIDTH-1:0] rd_index;
    logic [TAG_WIDTH-1:0]   lookup_tag;   // compare tag and fill tag
    way_mask_t              tag_we;
    way_mask_t              dirty_set;
    way_mask_t              hit_way;
    logic                   victim_dirty;
    logic [TAG_WIDTH-1:0]   victim_tag;
    way_mask_t              word_we;
    way_mask_t              fill_we;
    logic [INDEX_WIDTH-1:0] wr_index;
    word_sel_t              wr_word_sel;
    word_t                  store_wdata;
    wstrb_t                 store_wstrb;
    line_t                  fill_line;
    line_t                  rd_line0;
    line_t                  rd_line1;
    logic                   plru_update;
    way_mask_t              plru_way;
    way_mask_t              victim_way;

    dcache_ctrl #(
        .NUM_SETS(NUM_SETS)
    ) u_ctrl (
        .clk              (clk),
        .reset            (reset),
        .req_valid        (req_valid),
        .req_write        (req_write),
        .req_addr         (req_addr),
        .req_wdata        (req_wdata),
        .req_wstrb        (req_wstrb),
        .req_ready        (req_ready),
        .resp_valid       (resp_valid),
        .resp_rdata       (resp_rdata),
        .mem_rd_valid     (mem_rd_valid),
        .mem_rd_addr      (mem_rd_addr),
        .mem_rd_ready     (mem_rd_ready),
        .mem_rd_data_valid(mem_rd_data_valid),
        .mem_rd_data      (mem_rd_data),
        .mem_wr_valid     (mem_wr_valid),
        .mem_wr_addr      (mem_wr_addr),
        .mem_wr_data      (mem_wr_data),
        .mem_wr_ready     (mem_wr_ready),
        .rd_en            (rd_en),
        .rd_index         (rd_index),
        .tag_we           (tag_we),
        .dirty_set        (dirty_set),
        .wr_tag           (lookup_tag),
        .hit_way          (hit_way),
        .victim_dirty     (victim_dirty),
        .victim_tag       (victim_tag),
        .word_we          (word_we),
        .fill_we          (fill_we),
        .wr_index         (wr_index),
        .wr_word_sel      (wr_word_sel),
        .store_wdata      (store_wdata),
        .store_wstrb      (store_wstrb),
        .fill_line        (fill_line),
        .rd_line0         (rd_line0),
        .rd_line1         (rd_line1),
        .plru_update      (plru_update),
        .plru_way         (plru_way),
        .victim_way       (victim_way)
    );

    tag_array #(
        .NUM_SETS(NUM_SETS)
    ) u_tags (
        .clk         (clk),
        .reset       (reset),
        .rd_en       (rd_en),
        .rd_index    (rd_index),
        .rd_tag      (lookup_tag),
        .tag_we      (tag_we),
        .dirty_set   (dirty_set),
        .wr_tag      (lookup_tag),
        .victim_way  (victim_way),
        .hit_way     (hit_way),
        .victim_dirty(victim_dirty),
        .victim_tag  (victim_tag)
    );

    data_array #(
        .NUM_SETS(NUM_SETS)
    ) u_data (
        .clk        (clk),
        .rd_en      (rd_en),
        .rd_index   (rd_index),
        .word_we    (word_we),
        .fill_we    (fill_we),
        .wr_index   (wr_index),
        .wr_word_sel(wr_word_sel),
        .store_wdata(store_wdata),
        .store_wstrb(store_wstrb),
        .fill_line  (fill_line),
        .rd_line0   (rd_line0),
        .rd_line1   (rd_line1)
    );

    // replacement follows the set of the held request
    plru_table #(
        .NUM_SETS(NUM_SETS)
    ) u_plru (
        .clk       (clk),
        .reset     (reset),
        .index     (wr_index),
        .update    (plru_update),
        .used_way  (plru_way),
        .victim_way(victim_way)
    );

endmodule

`default_nettype wire

// File: src/dcache_ctrl.sv
`default_nettype none
`timescale 1ns/1ns

module dcache_ctrl
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 16,
    localparam int INDEX_WIDTH = $clog2(NUM_SETS),
    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req_valid,
    input  logic                   req_write,
    input  addr_t                  req_addr,
    input  word_t                  req_wdata,
    input  wstrb_t                 req_wstrb,
    output logic                   req_ready,
    output logic                   resp_valid,
    output word_t                  resp_rdata,
    output logic                   mem_rd_valid,
    output addr_t                  mem_rd_addr,
    input  logic                   mem_rd_ready,
    input  logic                   mem_rd_data_valid,
    input  line_t                  mem_rd_data,
    output logic                   mem_wr_valid,
    output addr_t                  mem_wr_addr,
    output line_t                  mem_wr_data,
    input  logic                   mem_wr_ready,
    output logic                   rd_en,
    output logic [INDEX_WIDTH-1:0] rd_index,
    output way_mask_t              tag_we,
    output way_mask_t              dirty_set,
    output logic [TAG_WIDTH-1:0]   wr_tag,
    input  way_mask_t              hit_way,
    input  logic                   victim_dirty,
    input  logic [TAG_WIDTH-1:0]   victim_tag,
    output way_mask_t              word_we,
    output way_mask_t              fill_we,
    output logic [INDEX_WIDTH-1:0] wr_index,
    output word_sel_t              wr_word_sel,
    output word_t                  store_wdata,
    output wstrb_t                 store_wstrb,
    output line_t                  fill_line,
    input  line_t                  rd_line0,
    input  line_t                  rd_line1,
    output logic                   plru_update,
    output way_mask_t              plru_way,
    input  way_mask_t              victim_way
);

    ctrl_state_t state, state_next;

    logic   rq_valid;
    logic   store_pend;   // held request is a store
    addr_t  rq_addr;
    word_t  rq_wdata;
    wstrb_t rq_wstrb;

    logic                   accept;
    logic                   lookup_hit;
    logic                   done;
    logic                   refill_write;
    addr_t                  lookup_addr;
    line_t                  hit_line;
    line_t                  victim_line;
    logic [INDEX_WIDTH-1:0] rq_index;
    logic [TAG_WIDTH-1:0]   rq_tag;
    word_sel_t              rq_word;

    assign rq_index = rq_addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign rq_tag   = rq_addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign rq_word  = rq_addr[OFFSET_WIDTH-1 -: $bits(word_sel_t)];

    assign lookup_hit = |hit_way;
    assign done       = (state == LOOKUP) && rq_valid && lookup_hit;
    assign req_ready  = !rq_valid || (done && !store_pend); // a store hit blocks one cycle
    assign accept     = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            rq_valid   <= 1'b0;
            store_pend <= 1'b0;
        end else if (accept) begin
            rq_valid   <= 1'b1;
            store_pend <= req_write;
        end else if (done) begin
            rq_valid   <= 1'b0;
            store_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rq_addr  <= req_addr;
            rq_wdata <= req_wdata;
            rq_wstrb <= req_wstrb;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= LOOKUP;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            LOOKUP: begin
                if (rq_valid && !lookup_hit) begin
                    state_next = victim_dirty ? MISS_DIRTY : MISS_CLEAN;
                end
            end
            MISS_DIRTY: begin
                if (mem_wr_ready) begin
                    state_next = MISS_CLEAN;
                end
            end
            MISS_CLEAN: begin
                if (mem_rd_ready) begin
                    state_next = REFILL;
                end
            end
            REFILL: begin
                if (mem_rd_data_valid) begin
                    state_next = REFILL_DONE;
                end
            end
            default: state_next = LOOKUP;   // REFILL_DONE included
        endcase
    end

    // response word from the hit way
    assign hit_line   = hit_way[1] ? rd_line1 : rd_line0;
    assign resp_valid = done;
    assign resp_rdata = hit_line[rq_word*WORD_WIDTH +: WORD_WIDTH];

    // new request on accept, otherwise the held one
    assign lookup_addr = accept ? req_addr : rq_addr;
    assign rd_en       = accept || (state == REFILL_DONE);
    assign rd_index    = lookup_addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign wr_tag      = lookup_addr[ADDR_WIDTH-1 -: TAG_WIDTH];

    assign refill_write = (state == REFILL) && mem_rd_data_valid;
    assign tag_we       = refill_write ? victim_way : '0;
    assign fill_we      = refill_write ? victim_way : '0;
    assign word_we      = (done && store_pend) ? hit_way : '0;
    assign dirty_set    = (done && store_pend) ? hit_way : '0;

    assign wr_index    = rq_index;
    assign wr_word_sel = rq_word;
    assign store_wdata = rq_wdata;
    assign store_wstrb = rq_wstrb;
    assign fill_line   = mem_rd_data;

    assign plru_update = done || refill_write;
    assign plru_way    = done ? hit_way : victim_way;

    // victim line stays in the read registers until the refill
    assign victim_line  = victim_way[1] ? rd_line1 : rd_line0;
    assign mem_wr_valid = (state == MISS_DIRTY);
    assign mem_wr_addr  = {victim_tag, rq_index, {OFFSET_WIDTH{1'b0}}};
    assign mem_wr_data  = victim_line;
    assign mem_rd_valid = (state == MISS_CLEAN);
    assign mem_rd_addr  = {rq_tag, rq_index, {OFFSET_WIDTH{1'b0}}};

endmodule

`default_nettype wire

// File: src/plru_table.sv
`default_nettype none
`timescale 1ns/1ns

module plru_table
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 16,
    localparam int INDEX_WIDTH = $clog2(NUM_SETS)
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [INDEX_WIDTH-1:0] index,
    input  logic                   update,
    input  way_mask_t              used_way,
    output way_mask_t              victim_way
);

    // set bit means way 1 was used last
    logic [NUM_SETS-1:0] mru_way1;

    always_ff @(posedge clk) begin
        if (reset) begin
            mru_way1 <= '1;   // way 0 goes first
        end else if (update) begin
            mru_way1[index] <= (used_way == 2'b10);
        end
    end

    assign victim_way = mru_way1[index] ? 2'b01 : 2'b10;

endmodule

`default_nettype wire

// File: src/data_array.sv
`default_nettype none
`timescale 1ns/1ns

module data_array
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 16,
    localparam int INDEX_WIDTH = $clog2(NUM_SETS)
) (
    input  logic                   clk,
    input  logic                   rd_en,
    input  logic [INDEX_WIDTH-1:0] rd_index,
    input  way_mask_t              word_we,
    input  way_mask_t              fill_we,
    input  logic [INDEX_WIDTH-1:0] wr_index,
    input  word_sel_t              wr_word_sel,
    input  word_t                  store_wdata,
    input  wstrb_t                 store_wstrb,
    input  line_t                  fill_line,
    output line_t                  rd_line0,
    output line_t                  rd_line1
);

    localparam int BYTES_PER_WORD = WORD_WIDTH / 8;

    line_t rd_line [2];

    for (genvar w = 0; w < 2; w++) begin : g_way
        line_t lines [NUM_SETS];
        line_t rd_q;

        // refill writes the whole line, a store only its strobed bytes
        always_ff @(posedge clk) begin
            if (fill_we[w]) begin
                lines[wr_index] <= fill_line;
            end else if (word_we[w]) begin
                for (int b = 0; b < BYTES_PER_WORD; b++) begin
                    if (store_wstrb[b]) begin
                        lines[wr_index][(wr_word_sel * BYTES_PER_WORD + b) * 8 +: 8] <=
                            store_wdata[b*8 +: 8];
                    end
                end
            end
        end

        always_ff @(posedge clk) begin
            if (rd_en) begin
                rd_q <= lines[rd_index];
            end
        end

        assign rd_line[w] = rd_q;
    end

    assign rd_line0 = rd_line[0];
    assign rd_line1 = rd_line[1];

endmodule

`default_nettype wire

// File: src/tag_array.sv
`default_nettype none
`timescale 1ns/1ns

module tag_array
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 16,
    localparam int INDEX_WIDTH = $clog2(NUM_SETS),
    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   rd_en,
    input  logic [INDEX_WIDTH-1:0] rd_index,   // also addresses tag and dirty writes
    input  logic [TAG_WIDTH-1:0]   rd_tag,
    input  way_mask_t              tag_we,
    input  way_mask_t              dirty_set,
    input  logic [TAG_WIDTH-1:0]   wr_tag,
    input  way_mask_t              victim_way,
    output way_mask_t              hit_way,
    output logic                   victim_dirty,
    output logic [TAG_WIDTH-1:0]   victim_tag
);

    logic [TAG_WIDTH-1:0] tag_rd [2];
    way_mask_t            dirty_rd;

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic [TAG_WIDTH-1:0] tags [NUM_SETS];
        logic [NUM_SETS-1:0]  valid;
        logic [NUM_SETS-1:0]  dirty;
        logic                 hit_q;
        logic                 dirty_q;
        logic [TAG_WIDTH-1:0] tag_q;

        always_ff @(posedge clk) begin
            if (tag_we[w]) begin
                tags[rd_index] <= wr_tag;
            end
        end

        // a fill makes the line valid and clean
        always_ff @(posedge clk) begin
            if (reset) begin
                valid <= '0;
                dirty <= '0;
            end else if (tag_we[w]) begin
                valid[rd_index] <= 1'b1;
                dirty[rd_index] <= 1'b0;
            end else if (dirty_set[w]) begin
                dirty[rd_index] <= 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (reset) begin
                hit_q   <= 1'b0;
                dirty_q <= 1'b0;
            end else if (rd_en) begin
                hit_q   <= valid[rd_index] && (tags[rd_index] == rd_tag);
                dirty_q <= valid[rd_index] && dirty[rd_index];
            end
        end

        always_ff @(posedge clk) begin
            if (rd_en) begin
                tag_q <= tags[rd_index];
            end
        end

        assign hit_way[w]  = hit_q;
        assign dirty_rd[w] = dirty_q;
        assign tag_rd[w]   = tag_q;
    end

    assign victim_dirty = victim_way[1] ? dirty_rd[1] : dirty_rd[0];
    assign victim_tag   = victim_way[1] ? tag_rd[1] : tag_rd[0];

endmodule

`default_nettype wire

// File: src/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    localparam int ADDR_WIDTH     = 32;
    localparam int WORD_WIDTH     = 32;
    localparam int WORDS_PER_LINE = 4;

    // byte offset inside one line
    localparam int OFFSET_WIDTH = $clog2(WORDS_PER_LINE * WORD_WIDTH / 8);

    typedef logic [ADDR_WIDTH-1:0]                addr_t;
    typedef logic [WORD_WIDTH-1:0]                word_t;
    typedef logic [WORD_WIDTH/8-1:0]              wstrb_t;
    typedef logic [WORDS_PER_LINE*WORD_WIDTH-1:0] line_t;
    typedef logic [$clog2(WORDS_PER_LINE)-1:0]    word_sel_t;

    // one bit for each of the two ways
    typedef logic [1:0] way_mask_t;

    typedef enum logic [2:0] {
        LOOKUP,
        MISS_DIRTY,   // write back the victim first
        MISS_CLEAN,
        REFILL,
        REFILL_DONE   // re-read the set after the fill
    } ctrl_state_t;

endpackage

`default_nettype wire
